//--- hdl/fixed_point_pkg.sv
`default_nettype none

package fixed_point_pkg;

   localparam int ANGLE_W = 20;                    // total bits of angle and sample words
   localparam int FRAC_W  = 16;                    // fraction bits, 1.0 = 65536

   typedef logic signed [ANGLE_W-1:0] angle_t;     // radians, s3.16
   typedef logic signed [ANGLE_W-1:0] sample_t;    // sine / cosine value, s3.16

   localparam angle_t PI     = 20'sd205887;        // pi * 2^16
   localparam angle_t PI_2   = 20'sd102943;        // pi/2, folding threshold
   localparam angle_t TWO_PI = 20'sd411774;        // one full turn, still fits s3.16

endpackage

`default_nettype wire

//--- hdl/cordic_pkg.sv
`default_nettype none

package cordic_pkg;

   localparam int ITERATIONS = 16;                 // one rotation step per clock

   // atan(2^-i) in s3.16 radians for i = 0..15
   localparam fixed_point_pkg::angle_t ATAN_TABLE [ITERATIONS] = '{
      20'sh0c90f,                                  // atan(1)      = 0.7854
      20'sh076b1,                                  // atan(1/2)    = 0.4636
      20'sh03eb6,                                  // atan(1/4)    = 0.2450
      20'sh01fd5,                                  // atan(1/8)    = 0.1244
      20'sh00ffa,                                  // atan(1/16)
      20'sh007ff,
      20'sh003ff,
      20'sh001ff,
      20'sh000ff,                                  // from here atan(x) ~ x
      20'sh0007f,
      20'sh0003f,
      20'sh0001f,
      20'sh0000f,
      20'sh00007,
      20'sh00003,
      20'sh00001                                   // atan(2^-15) is one lsb
   };

   // start vector (1, 0) with the gain applied afterwards
   localparam fixed_point_pkg::sample_t X_INIT =
      fixed_point_pkg::sample_t'(1 << fixed_point_pkg::FRAC_W);

   // 1/2 + 1/16 + 1/32 + 1/64 = 0.609375 which is close to 1/1.6468
   localparam int GAIN_SHIFTS [4] = '{1, 4, 5, 6};

endpackage

`default_nettype wire

//--- hdl/cordic_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cordic_if;
   import fixed_point_pkg::*;

   logic    req;                                   // level request from controller
   angle_t  theta;                                 // angle, stable while req is high
   sample_t sin_v;                                 // result, valid with ack
   sample_t cos_v;
   logic    ack;                                   // high from result until req falls

   modport ctrl (output req, theta, input sin_v, cos_v, ack);
   modport core (input req, theta, output sin_v, cos_v, ack);

endinterface

`default_nettype wire

//--- hdl/phase_accum.sv
`timescale 1ns/1ps
`default_nettype none

module phase_accum (
   input  wire                          i_clk,
   input  wire                          i_nrst,
   input  wire                          i_load,      // pulse, restart at i_phase0
   input  wire fixed_point_pkg::angle_t i_phase0,
   input  wire                          i_run,       // level, keep producing
   input  wire fixed_point_pkg::angle_t i_freq,      // phase step per sample
   input  wire                          i_full,
   output logic                         o_wr_en,
   output fixed_point_pkg::angle_t      o_wr_data
);
   import fixed_point_pkg::*;

   angle_t                  phase;                   // running phase, in [-pi, pi)
   angle_t                  phase_next;
   logic signed [ANGLE_W:0] sum;                     // one extra bit, pi + step may exceed s3.16
   logic signed [ANGLE_W:0] wrapped;

   assign o_wr_en   = i_run && !i_full;              // stall while fifo full, phase holds
   assign o_wr_data = phase;

   assign sum = phase + i_freq;                      // sign-extended to 21 bits

   always_comb begin
      if (sum >= PI)
         wrapped = sum - TWO_PI;                     // crossed +pi
      else if (sum < -PI)
         wrapped = sum + TWO_PI;                     // crossed -pi
      else
         wrapped = sum;
   end

   assign phase_next = wrapped[ANGLE_W-1:0];         // back in range, top bit redundant

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)
         phase <= '0;
      else if (i_load)
         phase <= i_phase0;                          // load wins over stepping
      else if (o_wr_en)
         phase <= phase_next;                        // advance only on an accepted write
   end

endmodule

`default_nettype wire

//--- hdl/angle_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module angle_fifo #(
   parameter int FIFO_DEPTH = 8                       // power of two
) (
   input  wire                          i_clk,
   input  wire                          i_nrst,
   input  wire                          i_wr_en,
   input  wire fixed_point_pkg::angle_t i_wr_data,
   input  wire                          i_rd_en,
   output fixed_point_pkg::angle_t      o_rd_data,    // registered, valid one cycle after i_rd_en
   output logic                         o_full,
   output logic                         o_empty
);
   import fixed_point_pkg::*;

   localparam int ADDR_W = $clog2(FIFO_DEPTH);

   angle_t            mem [FIFO_DEPTH];               // circular storage
   logic [ADDR_W:0]   wr_ptr;                         // msb is the lap bit
   logic [ADDR_W:0]   rd_ptr;
   logic              wr_ok;
   logic              rd_ok;

   assign wr_ok = i_wr_en && !o_full;                 // write into a full fifo is dropped
   assign rd_ok = i_rd_en && !o_empty;                // read from an empty fifo is dropped

   // same address, different lap -> full; identical pointers -> empty
   assign o_empty = (wr_ptr == rd_ptr);
   assign o_full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                    (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_ok)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_ok)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (wr_ok)
         mem[wr_ptr[ADDR_W-1:0]] <= i_wr_data;
      if (rd_ok)
         o_rd_data <= mem[rd_ptr[ADDR_W-1:0]];        // output register, holds between reads
   end

endmodule

`default_nettype wire

//--- hdl/cordic_sincos.sv
`timescale 1ns/1ps
`default_nettype none

module cordic_sincos (
   input wire     i_clk,
   input wire     i_nrst,
   cordic_if.core bus
);
   import fixed_point_pkg::*;
   import cordic_pkg::*;

   localparam int CNT_W = $clog2(ITERATIONS) + 1;     // counts 0..ITERATIONS

   logic             more;                            // theta above +pi/2
   logic             less;                            // theta below -pi/2
   logic             fold;                            // result must be negated
   angle_t           target;                          // folded angle, within +-pi/2
   angle_t           beta;                            // angle reached so far
   angle_t           beta_next;
   angle_t           step_angle;
   logic             sigma;                           // rotation direction
   sample_t          x;                               // cosine accumulator, gain ~1.647
   sample_t          y;                               // sine accumulator
   sample_t          x_next;
   sample_t          y_next;
   sample_t          x_shift;
   sample_t          y_shift;
   logic [CNT_W-1:0] count;                           // iteration index
   logic             done;

   // multiply by ~0.609 as a sum of arithmetic shifts
   function automatic sample_t gain_corr(input sample_t v);
      sample_t acc;
      acc = '0;
      for (int k = 0; k < $size(GAIN_SHIFTS); k++)
         acc = acc + (v >>> GAIN_SHIFTS[k]);
      return acc;
   endfunction

   // bring the angle into the convergence range, sin/cos(t -+ pi) = -sin/-cos(t)
   assign more   = (bus.theta > PI_2);
   assign less   = (bus.theta < -PI_2);
   assign fold   = more || less;
   assign target = more ? bus.theta - PI :
                   less ? bus.theta + PI :
                          bus.theta;

   assign done       = (count == CNT_W'(ITERATIONS));
   assign step_angle = ATAN_TABLE[count[CNT_W-2:0]];  // index unused once done
   assign x_shift    = x >>> count;                   // arithmetic, keeps sign
   assign y_shift    = y >>> count;

   assign sigma     = (beta <= target);               // 1: still short, rotate ccw
   assign beta_next = sigma ? beta + step_angle : beta - step_angle;
   assign x_next    = sigma ? x - y_shift : x + y_shift;
   assign y_next    = sigma ? y + x_shift : y - x_shift;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         count   <= '0;
         beta    <= '0;
         x       <= X_INIT;
         y       <= '0;
         bus.ack <= 1'b0;
      end else if (!bus.req) begin                    // idle, rearm and drop ack
         count   <= '0;
         beta    <= '0;
         x       <= X_INIT;
         y       <= '0;
         bus.ack <= 1'b0;
      end else if (!done) begin
         count <= count + 1'b1;                       // one micro-rotation per clock
         beta  <= beta_next;
         x     <= x_next;
         y     <= y_next;
      end else begin
         bus.ack <= 1'b1;                             // 17th edge after req, held till req low
      end
   end

   // result register, loaded once on the same edge that raises ack
   always_ff @(posedge i_clk) begin
      if (bus.req && done && !bus.ack) begin
         bus.sin_v <= fold ? -gain_corr(y) : gain_corr(y);
         bus.cos_v <= fold ? -gain_corr(x) : gain_corr(x);
      end
   end

endmodule

`default_nettype wire

//--- hdl/cordic_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cordic_ctrl (
   input  wire                          i_clk,
   input  wire                          i_nrst,
   input  wire                          i_empty,
   input  wire fixed_point_pkg::angle_t i_rd_data,
   output logic                         o_rd_en,      // pop, data arrives next cycle
   cordic_if.ctrl                       bus,
   output logic                         o_valid,      // one-cycle strobe per sample
   output fixed_point_pkg::angle_t      o_angle,
   output fixed_point_pkg::sample_t     o_sin,
   output fixed_point_pkg::sample_t     o_cos
);

   typedef enum logic [1:0] {
      ST_IDLE,                                        // wait for an angle
      ST_FETCH,                                       // fifo read data arriving
      ST_BUSY,                                        // req high, wait for ack
      ST_GAP                                          // req low for one cycle
   } state_t;

   state_t state;
   logic   capture;                                   // result taken this cycle

   assign o_rd_en = (state == ST_IDLE) && !i_empty;
   assign capture = (state == ST_BUSY) && bus.ack;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= ST_IDLE;
         bus.req <= 1'b0;
         o_valid <= 1'b0;
      end else begin
         o_valid <= capture;                          // pulse, cleared next cycle
         case (state)
            ST_IDLE: begin
               if (!i_empty)
                  state <= ST_FETCH;                  // pop issued this cycle
            end
            ST_FETCH: begin
               bus.req <= 1'b1;                       // theta latched on the same edge
               state   <= ST_BUSY;
            end
            ST_BUSY: begin
               if (bus.ack) begin
                  bus.req <= 1'b0;                    // release core, ack clears behind us
                  state   <= ST_GAP;
               end
            end
            ST_GAP: begin
               state <= ST_IDLE;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // payload registers
   always_ff @(posedge i_clk) begin
      if (state == ST_FETCH)
         bus.theta <= i_rd_data;                      // held while req is high
      if (capture) begin
         o_angle <= bus.theta;                        // angle travels with its result
         o_sin   <= bus.sin_v;
         o_cos   <= bus.cos_v;
      end
   end

endmodule

`default_nettype wire

//--- hdl/tone_gen_top.sv
`timescale 1ns/1ps
`default_nettype none

module tone_gen_top #(
   parameter int FIFO_DEPTH = 8                        // angle buffer depth, power of two
) (
   input  wire                          i_clk,
   input  wire                          i_nrst,
   input  wire                          i_load,        // pulse, restart phase
   input  wire fixed_point_pkg::angle_t i_phase0,
   input  wire                          i_run,         // level, produce samples
   input  wire fixed_point_pkg::angle_t i_freq,
   output logic                         o_valid,
   output fixed_point_pkg::angle_t      o_angle,
   output fixed_point_pkg::sample_t     o_sin,
   output fixed_point_pkg::sample_t     o_cos
);
   import fixed_point_pkg::*;

   logic   wr_en;                                      // producer -> fifo
   angle_t wr_data;
   logic   full;
   logic   rd_en;                                      // fifo -> consumer
   angle_t rd_data;
   logic   empty;

   cordic_if u_cordic_bus ();                          // controller <-> core handshake

   phase_accum u_phase_accum (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_load    (i_load),
      .i_phase0  (i_phase0),
      .i_run     (i_run),
      .i_freq    (i_freq),
      .i_full    (full),
      .o_wr_en   (wr_en),
      .o_wr_data (wr_data)
   );

   angle_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_angle_fifo (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_wr_en   (wr_en),
      .i_wr_data (wr_data),
      .i_rd_en   (rd_en),
      .o_rd_data (rd_data),
      .o_full    (full),
      .o_empty   (empty)
   );

   cordic_ctrl u_cordic_ctrl (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_empty   (empty),
      .i_rd_data (rd_data),
      .o_rd_en   (rd_en),
      .bus       (u_cordic_bus.ctrl),
      .o_valid   (o_valid),
      .o_angle   (o_angle),
      .o_sin     (o_sin),
      .o_cos     (o_cos)
   );

   cordic_sincos u_cordic_sincos (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .bus       (u_cordic_bus.core)
   );

endmodule

`default_nettype wire

//--- sim/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
   parameter int MAX_SAMPLES = 16                       // longest run the bench can hand over
) (
   input  wire                           i_clk,
   input  wire                           i_valid,
   input  wire fixed_point_pkg::angle_t  i_angle,
   input  wire fixed_point_pkg::sample_t i_sin,
   input  wire fixed_point_pkg::sample_t i_cos,
   input  var  int                       i_run_id,      // bumped by the bench at each load
   input  var  int                       i_phase0,
   input  var  int                       i_freq,
   input  var  int                       i_count,       // samples expected in this run
   input  var  int                       i_exp_angle [MAX_SAMPLES],
   input  var  int                       i_exp_sin [MAX_SAMPLES],
   input  var  int                       i_exp_cos [MAX_SAMPLES],
   output int                            o_seen,        // samples taken in the current run
   output int                            o_errors
);
   import fixed_point_pkg::*;

   localparam int TOL = 700;                            // about 1% of full scale in lsb

   int cur_run  = 0;
   int phase    = 0;                                    // angle the wrap rule predicts next

   initial begin
      o_seen   = 0;
      o_errors = 0;
   end

   // one phase step folded back into [-pi, pi)
   function automatic int next_angle(input int a, input int step);
      int s;
      s = a + step;
      if (s >= PI)
         s = s - TWO_PI;
      else if (s < -PI)
         s = s + TWO_PI;
      return s;
   endfunction

   task automatic compare(input string field, input int expected, input int actual,
                          input int tol);
      int diff;
      diff = actual - expected;
      if (diff > tol || diff < -tol) begin
         $display("ERROR at %0t ns: run %0d sample %0d %s expected %0d got %0d",
                  $time, cur_run, o_seen, field, expected, actual);
         o_errors++;
      end
   endtask

   // outputs change on the rising edge so sample them mid-cycle
   always @(negedge i_clk) begin
      if (i_run_id != cur_run) begin                    // restart the sequence for a new run
         cur_run = i_run_id;
         phase   = i_phase0;
         o_seen  = 0;
      end
      if (i_valid) begin
         if (o_seen >= i_count) begin                   // duplicate, stale or pre-run pulse
            $display("unexpected o_valid at %0t ns, run %0d already gave its %0d samples",
                     $time, cur_run, i_count);
            o_errors++;
         end else begin
            compare("o_angle", phase, int'(i_angle), 0);                    // exact
            compare("o_angle vs file", i_exp_angle[o_seen], int'(i_angle), 0);
            compare("o_sin", i_exp_sin[o_seen], int'(i_sin), TOL);
            compare("o_cos", i_exp_cos[o_seen], int'(i_cos), TOL);
            if (int'(i_angle) < -PI || int'(i_angle) >= PI) begin
               $display("ERROR at %0t ns: run %0d sample %0d o_angle %0d is outside -pi to pi",
                        $time, cur_run, o_seen, i_angle);
               o_errors++;
            end
            phase  = next_angle(phase, i_freq);
            o_seen = o_seen + 1;
         end
      end
   end

endmodule

`default_nettype wire

//--- sim/tb_tone_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tone_gen;
   import fixed_point_pkg::*;

   localparam int MAX_SAMPLES   = 16;                   // per run record
   localparam int SAMPLE_CYCLES = 40;                   // bound per sample, core needs ~21

   logic    i_clk;
   logic    i_nrst;
   logic    i_load;
   angle_t  i_phase0;
   logic    i_run;
   angle_t  i_freq;
   logic    o_valid;
   angle_t  o_angle;
   sample_t o_sin;
   sample_t o_cos;

   int fd;                                              // stimulus file handle
   int run_id;
   int run_phase0;
   int run_freq;
   int run_count;
   int exp_angle [MAX_SAMPLES];
   int exp_sin   [MAX_SAMPLES];
   int exp_cos   [MAX_SAMPLES];
   int seen;                                            // from the checker
   int check_errors;
   int other_errors;
   int total;
   int accepted;                                        // angles the fifo took this run
   int cycles;

   tone_gen_top #(.FIFO_DEPTH(8)) UUT (.*);

   tb_checker #(.MAX_SAMPLES(MAX_SAMPLES)) u_checker (
      .i_clk       (i_clk),
      .i_valid     (o_valid),
      .i_angle     (o_angle),
      .i_sin       (o_sin),
      .i_cos       (o_cos),
      .i_run_id    (run_id),
      .i_phase0    (run_phase0),
      .i_freq      (run_freq),
      .i_count     (run_count),
      .i_exp_angle (exp_angle),
      .i_exp_sin   (exp_sin),
      .i_exp_cos   (exp_cos),
      .o_seen      (seen),
      .o_errors    (check_errors)
   );

   always #10 i_clk = ~i_clk;                           // 20 ns period

   // next line holding three numbers, '#' lines are comments
   task automatic next_record(output int f0, output int f1, output int f2, output bit ok);
      string line;
      int    n;
      ok = 1'b0;
      while (!ok && !$feof(fd)) begin
         line = "";
         n    = $fgets(line, fd);
         if (n > 0 && line.len() > 0 && line[0] != "#")
            ok = ($sscanf(line, "%d %d %d", f0, f1, f2) == 3);
      end
   endtask

   // load, stream exactly count angles into the fifo, wait for count results
   task automatic play_run(input int phase0, input int freq, input int count);
      @(negedge i_clk);
      run_phase0 = phase0;
      run_freq   = freq;
      run_count  = count;
      run_id     = run_id + 1;                          // checker restarts on this
      i_phase0   = angle_t'(phase0);
      i_freq     = angle_t'(freq);
      i_load     = 1'b1;                                // i_run low, nothing written now
      @(negedge i_clk);
      i_load   = 1'b0;
      accepted = 0;
      cycles   = 0;
      @(posedge i_clk);
      while (seen < count && cycles < SAMPLE_CYCLES * count) begin
         @(negedge i_clk);
         i_run = (accepted < count);                    // drop run after the last write
         if (i_run && !UUT.full)
            accepted++;                                 // write lands on the next edge
         cycles++;
         @(posedge i_clk);
      end
      if (seen < count) begin
         $display("timeout in run %0d, got %0d of %0d samples after %0d cycles",
                  run_id, seen, count, cycles);
         other_errors++;
      end
      total = total + seen;
      @(negedge i_clk);
      i_run = 1'b0;
      repeat (40) @(negedge i_clk);                     // fifo drains, extra pulses get flagged
   endtask

   initial begin
      int p0;
      int fr;
      int cnt;
      int lines;
      bit ok;
      i_clk        = 1'b0;
      i_nrst       = 1'b0;
      i_load       = 1'b0;
      i_phase0     = '0;
      i_run        = 1'b0;
      i_freq       = '0;
      run_id       = 0;
      run_phase0   = 0;
      run_freq     = 0;
      run_count    = 0;
      other_errors = 0;
      total        = 0;
      repeat (2) @(posedge i_clk);                      // reset for two cycles
      @(negedge i_clk);
      i_nrst = 1'b1;
      repeat (10) @(negedge i_clk);                     // idle, o_valid must stay low
      fd = $fopen("sim/tone_stimulus.txt", "r");
      if (fd == 0) begin
         $display("cannot open the stimulus file sim/tone_stimulus.txt");
         other_errors++;
      end else begin
         next_record(p0, fr, cnt, ok);
         while (ok && cnt >= 1 && cnt <= MAX_SAMPLES) begin
            lines = 0;
            for (int k = 0; k < cnt; k++) begin
               next_record(exp_angle[k], exp_sin[k], exp_cos[k], ok);
               if (ok)
                  lines++;
            end
            if (lines != cnt) begin
               $display("stimulus file holds %0d of %0d sample lines for a run", lines, cnt);
               other_errors++;
            end else
               play_run(p0, fr, cnt);
            next_record(p0, fr, cnt, ok);
         end
         if (ok) begin                                  // loop left on a bad count
            $display("stimulus file asks for %0d samples, limit is %0d", cnt, MAX_SAMPLES);
            other_errors++;
         end
         $fclose(fd);
      end
      @(posedge i_clk);
      $display("summary: %0d runs, %0d samples, %0d check errors, %0d other errors",
               run_id, total, check_errors, other_errors);
      if (check_errors == 0 && other_errors == 0 && run_id > 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/tone_stimulus.txt
# run record: phase0 freq count, angles in s3.16 radians (pi = 205887)
# then count sample lines: angle sin cos, true values scaled by 65536
0 150000 10
0 0 65536
150000 49356 -43116
-111774 -64942 -8804
38226 36095 54700
188226 17448 -63171
-73548 -59053 28420
76452 60254 25776
-185322 -20230 -62336
-35322 -33637 56245
114678 64488 -11672
-200000 -20000 4
-200000 -5880 -65272
191774 14005 -64022
171774 32594 -56856
151774 48171 -44436

//--- all.f
hdl/fixed_point_pkg.sv
hdl/cordic_pkg.sv
hdl/cordic_if.sv
hdl/phase_accum.sv
hdl/angle_fifo.sv
hdl/cordic_sincos.sv
hdl/cordic_ctrl.sv
hdl/tone_gen_top.sv
sim/tb_checker.sv
sim/tb_tone_gen.sv

//--- Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		--top-module tb_tone_gen -Mdir obj_dir -f all.f

run: compile
	./obj_dir/Vtb_tone_gen | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
